/* rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;

  localparam word_t RESET_PC = 32'h8000_0000;

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  localparam word_t INSTR_ECALL = 32'h0000_0073;
  localparam word_t INSTR_MRET  = 32'h3020_0073;

  typedef enum logic [3:0] {
    NOP, LUI, AUIPC, JAL, JALR, BRANCH, LOAD, STORE,
    ALU_IMM, ALU_REG, CSRRW, CSRRS, ECALL, MRET
  } op_class_e;

  typedef struct packed {
    op_class_e   op;
    logic [2:0]  funct3;
    logic        alt;          // Bit 30 variant, sub and sra
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    reg_idx_t    rd;
    word_t       imm;
    logic [11:0] csr_addr;
  } dec_t;

  typedef struct packed {
    word_t      alu_result;
    logic       branch_taken;
    word_t      target;
    word_t      mem_addr;
    word_t      mem_wdata;
    logic [3:0] mem_wstrb;
  } exec_t;

  typedef struct packed {
    logic       rd;
    logic       wr;
    word_t      addr;
    word_t      wdata;
    logic [3:0] wstrb;
  } mem_req_t;

  typedef struct packed {
    word_t    pc;
    word_t    instr;
    logic     rd_wen;
    reg_idx_t rd;
    word_t    rd_wdata;
  } retire_t;

endpackage

`default_nettype wire

/* rv_csr_pkg.sv */
`default_nettype none

package rv_csr_pkg;

  import rv_isa_pkg::*;

  localparam logic [11:0] CSR_MSTATUS = 12'h300;
  localparam logic [11:0] CSR_MTVEC   = 12'h305;
  localparam logic [11:0] CSR_MEPC    = 12'h341;
  localparam logic [11:0] CSR_MCAUSE  = 12'h342;

  localparam word_t MSTATUS_RESET  = 32'h0000_1800;
  localparam word_t MCAUSE_ECALL_M = 32'd11;

  localparam int MSTATUS_MIE    = 3;
  localparam int MSTATUS_MPIE   = 7;
  localparam int MSTATUS_MPP_LO = 11;
  localparam int MSTATUS_MPP_HI = 12;

  typedef struct packed {
    word_t rdata;        // Old CSR value
    logic  redirect;
    word_t redirect_pc;
  } csr_res_t;

endpackage

`default_nettype wire

/* rv_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_decoder import rv_isa_pkg::*; (
  input  word_t instr,
  output dec_t  dec
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  always_comb begin
    dec          = '0;
    dec.op       = NOP;
    dec.funct3   = funct3;
    dec.alt      = instr[30];
    dec.rs1      = instr[19:15];
    dec.rs2      = instr[24:20];
    dec.rd       = instr[11:7];
    dec.csr_addr = instr[31:20];

    case (opcode)
      OPC_LUI:    dec.op = LUI;
      OPC_AUIPC:  dec.op = AUIPC;
      OPC_JAL:    dec.op = JAL;
      OPC_JALR:   if (funct3 == 3'b000) dec.op = JALR;
      OPC_BRANCH: if (funct3 != 3'b010 && funct3 != 3'b011) dec.op = BRANCH;
      OPC_LOAD:   if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) dec.op = LOAD;
      OPC_STORE:  if (funct3 inside {3'b000, 3'b001, 3'b010}) dec.op = STORE;
      OPC_OPIMM: begin
        if (funct3 == 3'b001) begin
          if (funct7 == 7'b0000000) dec.op = ALU_IMM;
        end else if (funct3 == 3'b101) begin
          if (funct7 inside {7'b0000000, 7'b0100000}) dec.op = ALU_IMM;
        end else begin
          dec.op = ALU_IMM;
        end
      end
      OPC_OP: begin
        if (funct7 == 7'b0000000) begin
          dec.op = ALU_REG;
        end else if (funct7 == 7'b0100000 && funct3 inside {3'b000, 3'b101}) begin
          dec.op = ALU_REG;                              // sub, sra
        end
      end
      OPC_SYSTEM: begin
        if (instr == INSTR_ECALL)    dec.op = ECALL;
        else if (instr == INSTR_MRET) dec.op = MRET;
        else if (funct3 == 3'b001)   dec.op = CSRRW;
        else if (funct3 == 3'b010)   dec.op = CSRRS;
      end
      default: dec.op = NOP;
    endcase

    case (dec.op)
      LUI, AUIPC: dec.imm = {instr[31:12], 12'b0};
      JAL:        dec.imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      BRANCH:     dec.imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      STORE:      dec.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      default:    dec.imm = {{20{instr[31]}}, instr[31:20]};
    endcase
  end

endmodule

`default_nettype wire

/* rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_regfile import rv_isa_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,
  input  dec_t     dec,
  input  logic     wen,
  input  reg_idx_t waddr,
  input  word_t    wdata,
  output word_t    rs1_data,
  output word_t    rs2_data
);

  word_t regs [1:31];  // x0 has no storage

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  assign rs1_data = (dec.rs1 == '0) ? '0 : regs[dec.rs1];
  assign rs2_data = (dec.rs2 == '0) ? '0 : regs[dec.rs2];

endmodule

`default_nettype wire

/* rv_int_exec.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_int_exec import rv_isa_pkg::*; (
  input  word_t pc,
  input  dec_t  dec,
  input  word_t rs1_data,
  input  word_t rs2_data,
  output exec_t ex
);

  word_t      op_b;
  logic [4:0] shamt;
  logic       cond;
  logic [1:0] lane;

  assign op_b  = (dec.op == ALU_REG) ? rs2_data : dec.imm;
  assign shamt = op_b[4:0];  // Low five bits only

  always_comb begin
    case (dec.funct3)
      3'b000: ex.alu_result = (dec.op == ALU_REG && dec.alt) ? rs1_data - op_b
                                                             : rs1_data + op_b;
      3'b001: ex.alu_result = rs1_data << shamt;
      3'b010: ex.alu_result = {31'b0, $signed(rs1_data) < $signed(op_b)};
      3'b011: ex.alu_result = {31'b0, rs1_data < op_b};
      3'b100: ex.alu_result = rs1_data ^ op_b;
      3'b101: ex.alu_result = dec.alt ? word_t'($signed(rs1_data) >>> shamt)
                                      : rs1_data >> shamt;
      3'b110: ex.alu_result = rs1_data | op_b;
      default: ex.alu_result = rs1_data & op_b;
    endcase
  end

  always_comb begin
    case (dec.funct3)
      3'b000:  cond = (rs1_data == rs2_data);
      3'b001:  cond = (rs1_data != rs2_data);
      3'b100:  cond = ($signed(rs1_data) <  $signed(rs2_data));
      3'b101:  cond = ($signed(rs1_data) >= $signed(rs2_data));
      3'b110:  cond = (rs1_data <  rs2_data);
      3'b111:  cond = (rs1_data >= rs2_data);
      default: cond = 1'b0;
    endcase
  end

  assign ex.branch_taken = (dec.op == JAL) || (dec.op == JALR) || (dec.op == BRANCH && cond);
  assign ex.target       = (dec.op == JALR) ? ((rs1_data + dec.imm) & ~32'd1)
                                            : pc + dec.imm;

  assign ex.mem_addr  = rs1_data + dec.imm;
  assign lane         = ex.mem_addr[1:0];
  assign ex.mem_wdata = rs2_data << {lane, 3'b000};  // Data into addressed lanes

  always_comb begin
    if (dec.op != STORE) begin
      ex.mem_wstrb = 4'b0000;
    end else begin
      case (dec.funct3)
        3'b000:  ex.mem_wstrb = 4'b0001 << lane;
        3'b001:  ex.mem_wstrb = 4'b0011 << lane;
        default: ex.mem_wstrb = 4'b1111;
      endcase
    end
  end

endmodule

`default_nettype wire

/* rv_csr_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_csr_unit import rv_isa_pkg::*, rv_csr_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,
  input  word_t    pc,
  input  dec_t     dec,
  input  word_t    rs1_data,
  output csr_res_t csr,
  output word_t    mepc,
  output word_t    mcause,
  output word_t    mstatus,
  output word_t    mtvec
);

  word_t old_val;
  word_t wval;

  always_comb begin
    case (dec.csr_addr)
      CSR_MSTATUS: old_val = mstatus;
      CSR_MTVEC:   old_val = mtvec;
      CSR_MEPC:    old_val = mepc;
      CSR_MCAUSE:  old_val = mcause;
      default:     old_val = '0;  // Unknown CSR
    endcase
  end

  assign wval            = (dec.op == CSRRW) ? rs1_data : (old_val | rs1_data);
  assign csr.rdata       = old_val;
  assign csr.redirect    = (dec.op == ECALL) || (dec.op == MRET);
  assign csr.redirect_pc = (dec.op == ECALL) ? mtvec : mepc;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mepc    <= '0;
      mcause  <= '0;
      mstatus <= MSTATUS_RESET;
      mtvec   <= '0;
    end else if (dec.op == ECALL) begin
      mepc                                  <= pc;
      mcause                                <= MCAUSE_ECALL_M;
      mstatus[MSTATUS_MPIE]                 <= mstatus[MSTATUS_MIE];
      mstatus[MSTATUS_MIE]                  <= 1'b0;
      mstatus[MSTATUS_MPP_HI:MSTATUS_MPP_LO] <= 2'b11;  // Machine mode
    end else if (dec.op == MRET) begin
      mstatus[MSTATUS_MIE]                  <= mstatus[MSTATUS_MPIE];
      mstatus[MSTATUS_MPIE]                 <= 1'b1;
      mstatus[MSTATUS_MPP_HI:MSTATUS_MPP_LO] <= 2'b00;
    end else if (dec.op == CSRRW || dec.op == CSRRS) begin
      case (dec.csr_addr)
        CSR_MSTATUS: mstatus <= wval;
        CSR_MTVEC:   mtvec   <= wval;
        CSR_MEPC:    mepc    <= wval;
        CSR_MCAUSE:  mcause  <= wval;
        default:     ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* rv_commit.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_commit import rv_isa_pkg::*, rv_csr_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,
  input  word_t    instr,
  input  dec_t     dec,
  input  exec_t    ex,
  input  csr_res_t csr,
  input  word_t    mem_rdata,
  output word_t    pc,
  output logic     rf_wen,
  output reg_idx_t rf_waddr,
  output word_t    rf_wdata,
  output retire_t  retire
);

  word_t pc_plus4;
  word_t lane_data;
  word_t load_val;

  assign pc_plus4  = pc + 32'd4;
  assign lane_data = mem_rdata >> {ex.mem_addr[1:0], 3'b000};  // Addressed lane to bit 0

  always_comb begin
    case (dec.funct3)
      3'b000:  load_val = {{24{lane_data[7]}}, lane_data[7:0]};
      3'b001:  load_val = {{16{lane_data[15]}}, lane_data[15:0]};
      3'b100:  load_val = {24'b0, lane_data[7:0]};
      3'b101:  load_val = {16'b0, lane_data[15:0]};
      default: load_val = lane_data;
    endcase
  end

  always_comb begin
    case (dec.op)
      LUI:          rf_wdata = dec.imm;
      AUIPC:        rf_wdata = pc + dec.imm;
      JAL, JALR:    rf_wdata = pc_plus4;  // Link
      LOAD:         rf_wdata = load_val;
      CSRRW, CSRRS: rf_wdata = csr.rdata;
      default:      rf_wdata = ex.alu_result;
    endcase
  end

  assign rf_wen   = dec.op inside {LUI, AUIPC, JAL, JALR, LOAD, ALU_IMM, ALU_REG, CSRRW, CSRRS};
  assign rf_waddr = dec.rd;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= RESET_PC;
    end else if (csr.redirect) begin
      pc <= csr.redirect_pc;
    end else if (ex.branch_taken) begin
      pc <= ex.target;
    end else begin
      pc <= pc_plus4;
    end
  end

  assign retire.pc       = pc;
  assign retire.instr    = instr;
  assign retire.rd_wen   = rf_wen;
  assign retire.rd       = rf_waddr;
  assign retire.rd_wdata = rf_wdata;

endmodule

`default_nettype wire

/* rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_isa_pkg::*, rv_csr_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,
  output word_t    pc,
  input  word_t    instr,
  output mem_req_t mem_req,
  input  word_t    mem_rdata,
  output retire_t  retire,
  output word_t    mepc,
  output word_t    mcause,
  output word_t    mstatus,
  output word_t    mtvec
);

  dec_t     dec;
  word_t    rs1_data;
  word_t    rs2_data;
  exec_t    ex;
  csr_res_t csr;
  logic     rf_wen;
  reg_idx_t rf_waddr;
  word_t    rf_wdata;

  rv_decoder u_decoder (
    .instr (instr),
    .dec   (dec)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .arst_n   (arst_n),
    .dec      (dec),
    .wen      (rf_wen),
    .waddr    (rf_waddr),
    .wdata    (rf_wdata),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_int_exec u_int_exec (
    .pc       (pc),
    .dec      (dec),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .ex       (ex)
  );

  rv_csr_unit u_csr_unit (
    .clk      (clk),
    .arst_n   (arst_n),
    .pc       (pc),
    .dec      (dec),
    .rs1_data (rs1_data),
    .csr      (csr),
    .mepc     (mepc),
    .mcause   (mcause),
    .mstatus  (mstatus),
    .mtvec    (mtvec)
  );

  rv_commit u_commit (
    .clk       (clk),
    .arst_n    (arst_n),
    .instr     (instr),
    .dec       (dec),
    .ex        (ex),
    .csr       (csr),
    .mem_rdata (mem_rdata),
    .pc        (pc),
    .rf_wen    (rf_wen),
    .rf_waddr  (rf_waddr),
    .rf_wdata  (rf_wdata),
    .retire    (retire)
  );

  assign mem_req.rd    = (dec.op == LOAD);
  assign mem_req.wr    = (dec.op == STORE);
  assign mem_req.addr  = ex.mem_addr;  // Byte address, memory aligns the word
  assign mem_req.wdata = ex.mem_wdata;
  assign mem_req.wstrb = ex.mem_wstrb;

endmodule

`default_nettype wire

/* tb_rv_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_checker import rv_isa_pkg::*, rv_csr_pkg::*; (
  input wire logic     clk,
  input wire logic     arst_n,
  input wire word_t    pc,
  input wire word_t    instr,
  input wire mem_req_t mem_req,
  input wire retire_t  retire,
  input wire word_t    mepc,
  input wire word_t    mcause,
  input wire word_t    mstatus,
  input wire word_t    mtvec
);

  // Architectural state of the reference model
  word_t      xr [0:31];
  word_t      r_pc;
  word_t      r_mepc;
  word_t      r_mcause;
  word_t      r_mstatus;
  word_t      r_mtvec;
  logic [7:0] shadow [word_t];  // Bytes written by stores

  // Prediction for the current instruction
  logic       e_wen;
  reg_idx_t   e_rd;
  word_t      e_wd;
  logic       e_mrd;
  logic       e_mwr;
  word_t      e_addr;
  word_t      e_wdata;
  logic [3:0] e_wstrb;

  int checks_test = 0;
  int errs_test   = 0;
  int checks_all  = 0;
  int err_total   = 0;
  int tests_run   = 0;

  function automatic logic [7:0] fill_byte(input word_t addr);
    return addr[7:0] ^ addr[15:8] ^ addr[23:16] ^ addr[31:24] ^ 8'h5a;
  endfunction

  function automatic logic [7:0] read_byte(input word_t addr);
    if (shadow.exists(addr)) return shadow[addr];
    return fill_byte(addr);
  endfunction

  function automatic word_t csr_read(input logic [11:0] ca);
    case (ca)
      CSR_MSTATUS: return r_mstatus;
      CSR_MTVEC:   return r_mtvec;
      CSR_MEPC:    return r_mepc;
      CSR_MCAUSE:  return r_mcause;
      default:     return '0;
    endcase
  endfunction

  function automatic void csr_write(input logic [11:0] ca, input word_t v);
    case (ca)
      CSR_MSTATUS: r_mstatus = v;
      CSR_MTVEC:   r_mtvec   = v;
      CSR_MEPC:    r_mepc    = v;
      CSR_MCAUSE:  r_mcause  = v;
      default:     ;
    endcase
  endfunction

  function automatic word_t alu_ref(input logic [2:0] f3, input logic sub, input logic sra,
                                    input word_t a, input word_t b);
    case (f3)
      3'd0:    return sub ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'b0, $signed(a) < $signed(b)};
      3'd3:    return {31'b0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return sra ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  // One architectural step of RV32I machine mode
  function automatic void rv_step(input word_t ins);
    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    reg_idx_t   rd;
    word_t      a;
    word_t      b;
    word_t      ii;
    word_t      si;
    word_t      bi;
    word_t      ji;
    word_t      npc;
    word_t      addr;
    word_t      v;
    word_t      oldv;
    logic       take;
    int         nb;
    int         lo;
    opc  = ins[6:0];
    f3   = ins[14:12];
    f7   = ins[31:25];
    rd   = ins[11:7];
    a    = xr[ins[19:15]];
    b    = xr[ins[24:20]];
    ii   = {{20{ins[31]}}, ins[31:20]};
    si   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    bi   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    ji   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    npc  = r_pc + 32'd4;
    nb   = (f3[1:0] == 2'd0) ? 1 : (f3[1:0] == 2'd1) ? 2 : 4;
    e_wen = 1'b0;
    e_wd  = '0;
    e_mrd = 1'b0;
    e_mwr = 1'b0;
    e_addr = '0;
    e_wdata = '0;
    e_wstrb = '0;
    e_rd  = rd;
    case (opc)
      OPC_LUI: begin
        e_wen = 1'b1;
        e_wd  = {ins[31:12], 12'b0};
      end
      OPC_AUIPC: begin
        e_wen = 1'b1;
        e_wd  = r_pc + {ins[31:12], 12'b0};
      end
      OPC_JAL: begin
        e_wen = 1'b1;
        e_wd  = r_pc + 32'd4;
        npc   = r_pc + ji;
      end
      OPC_JALR: if (f3 == 3'd0) begin
        e_wen = 1'b1;
        e_wd  = r_pc + 32'd4;
        npc   = (a + ii) & ~32'd1;
      end
      OPC_BRANCH: begin
        case (f3)
          3'd0:    take = (a == b);
          3'd1:    take = (a != b);
          3'd4:    take = ($signed(a) < $signed(b));
          3'd5:    take = ($signed(a) >= $signed(b));
          3'd6:    take = (a < b);
          3'd7:    take = (a >= b);
          default: take = 1'b0;
        endcase
        if (take) npc = r_pc + bi;
      end
      OPC_LOAD: if (f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5}) begin
        addr   = a + ii;
        e_mrd  = 1'b1;
        e_addr = addr;
        e_wen  = 1'b1;
        v      = '0;
        for (int k = 0; k < nb; k++) v[8*k +: 8] = read_byte(addr + k);
        case (f3)
          3'd0:    e_wd = {{24{v[7]}}, v[7:0]};
          3'd1:    e_wd = {{16{v[15]}}, v[15:0]};
          default: e_wd = v;
        endcase
      end
      OPC_STORE: if (f3 < 3'd3) begin
        addr    = a + si;
        lo      = addr[1:0];
        e_mwr   = 1'b1;
        e_addr  = addr;
        for (int k = 0; k < nb; k++) begin
          e_wstrb[lo + k]          = 1'b1;  // Byte lanes from the low address bits
          e_wdata[8*(lo + k) +: 8] = b[8*k +: 8];
          shadow[addr + k]         = b[8*k +: 8];
        end
      end
      OPC_OPIMM: if (f3 == 3'd1 ? f7 == 7'h00 :
                     f3 == 3'd5 ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1) begin
        e_wen = 1'b1;
        e_wd  = alu_ref(f3, 1'b0, ins[30], a, ii);
      end
      OPC_OP: if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
        e_wen = 1'b1;
        e_wd  = alu_ref(f3, ins[30], ins[30], a, b);
      end
      OPC_SYSTEM: begin
        if (ins == 32'h0000_0073) begin  // ecall
          r_mepc     = r_pc;
          r_mcause   = MCAUSE_ECALL_M;
          r_mstatus[7] = r_mstatus[3];
          r_mstatus[3] = 1'b0;
          r_mstatus[12:11] = 2'b11;
          npc = r_mtvec;
        end else if (ins == 32'h3020_0073) begin  // mret
          r_mstatus[3] = r_mstatus[7];
          r_mstatus[7] = 1'b1;
          r_mstatus[12:11] = 2'b00;
          npc = r_mepc;
        end else if (f3 == 3'd1 || f3 == 3'd2) begin
          oldv  = csr_read(ins[31:20]);
          e_wen = 1'b1;
          e_wd  = oldv;
          csr_write(ins[31:20], (f3 == 3'd1) ? a : (oldv | a));
        end
      end
      default: ;
    endcase
    if (e_wen && rd != 5'd0) xr[rd] = e_wd;
    r_pc = npc;
  endfunction

  task automatic check(input string field, input word_t got, input word_t exp);
    checks_test++;
    if (got !== exp) begin
      errs_test++;
      $display("** Error @%0t: %s got %h expected %h", $time, field, got, exp);
    end
  endtask

  task automatic end_test(input string name);
    $display("test %-8s %0d checks, %0d errors", name, checks_test, errs_test);
    tests_run++;
    checks_all += checks_test;
    err_total  += errs_test;
    checks_test = 0;
    errs_test   = 0;
  endtask

  word_t lane_mask;

  always @(negedge clk) begin
    if (!arst_n) begin
      for (int i = 0; i < 32; i++) xr[i] = '0;
      r_pc      = RESET_PC;
      r_mepc    = '0;
      r_mcause  = '0;
      r_mstatus = MSTATUS_RESET;
      r_mtvec   = '0;
      shadow.delete();
    end else begin
      check("pc", pc, r_pc);
      check("retire.pc", retire.pc, r_pc);
      check("retire.instr", retire.instr, instr);
      check("mepc", mepc, r_mepc);  // CSRs before this instruction retires
      check("mcause", mcause, r_mcause);
      check("mstatus", mstatus, r_mstatus);
      check("mtvec", mtvec, r_mtvec);
      rv_step(instr);
      check("rd_wen", 32'(retire.rd_wen), 32'(e_wen));
      if (e_wen) begin
        check("rd", 32'(retire.rd), 32'(e_rd));
        check("rd_wdata", retire.rd_wdata, e_wd);
      end
      check("mem_rd", 32'(mem_req.rd), 32'(e_mrd));
      check("mem_wr", 32'(mem_req.wr), 32'(e_mwr));
      if (e_mrd || e_mwr) check("mem_addr", mem_req.addr, e_addr);
      if (e_mwr) begin
        lane_mask = {{8{e_wstrb[3]}}, {8{e_wstrb[2]}}, {8{e_wstrb[1]}}, {8{e_wstrb[0]}}};
        check("mem_wstrb", 32'(mem_req.wstrb), 32'(e_wstrb));
        check("mem_wdata", mem_req.wdata & lane_mask, e_wdata & lane_mask);
      end
    end
  end

endmodule

`default_nettype wire

/* tb_rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core import rv_isa_pkg::*, rv_csr_pkg::*;;

  localparam int    CYCLE_LIMIT = 1500;  // Five programs, about 700 instructions
  localparam word_t DMEM_BASE   = 32'h8001_0000;

  logic       clk;
  logic       arst_n;
  word_t      pc;
  word_t      instr;
  mem_req_t   mem_req;
  word_t      mem_rdata;
  retire_t    retire;
  word_t      mepc;
  word_t      mcause;
  word_t      mstatus;
  word_t      mtvec;

  word_t      imem [0:1023];
  logic [7:0] dmem [0:4095];
  mem_req_t   wr_q;
  integer     seed;
  int         wp;
  int         cycles;
  word_t      end_pc;

  rv_core dut (
    .clk       (clk),
    .arst_n    (arst_n),
    .pc        (pc),
    .instr     (instr),
    .mem_req   (mem_req),
    .mem_rdata (mem_rdata),
    .retire    (retire),
    .mepc      (mepc),
    .mcause    (mcause),
    .mstatus   (mstatus),
    .mtvec     (mtvec)
  );

  tb_rv_checker chk (
    .clk     (clk),
    .arst_n  (arst_n),
    .pc      (pc),
    .instr   (instr),
    .mem_req (mem_req),
    .retire  (retire),
    .mepc    (mepc),
    .mcause  (mcause),
    .mstatus (mstatus),
    .mtvec   (mtvec)
  );

  assign instr = imem[pc[11:2]];

  always_comb begin
    mem_rdata = {dmem[{mem_req.addr[11:2], 2'd3}], dmem[{mem_req.addr[11:2], 2'd2}],
                 dmem[{mem_req.addr[11:2], 2'd1}], dmem[{mem_req.addr[11:2], 2'd0}]};
  end

  always @(negedge clk) wr_q <= mem_req;

  always @(posedge clk) begin
    #1;
    if (!arst_n) begin
      for (int i = 0; i < 4096; i++) begin
        dmem[i] = chk.fill_byte(DMEM_BASE + i);
      end
    end else if (wr_q.wr) begin
      for (int j = 0; j < 4; j++) begin
        if (wr_q.wstrb[j]) dmem[{wr_q.addr[11:2], 2'(j)}] = wr_q.wdata[8*j +: 8];
      end
    end
  end

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: the programs did not finish within %0d cycles", CYCLE_LIMIT);
      $display("=== FAIL ===");
      $finish;
    end
  end

  function automatic word_t enc_i(input logic [11:0] imm, input int rs1, input logic [2:0] f3,
                                  input int rd, input logic [6:0] opc);
    return {imm, 5'(rs1), f3, 5'(rd), opc};
  endfunction

  function automatic word_t enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                  input logic [2:0] f3, input int rd);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_OP};
  endfunction

  function automatic word_t enc_s(input logic [11:0] imm, input int rs2, input int rs1,
                                  input logic [2:0] f3);
    return {imm[11:5], 5'(rs2), 5'(rs1), f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic word_t enc_b(input logic [12:0] imm, input int rs2, input int rs1,
                                  input logic [2:0] f3);
    return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic word_t enc_u(input logic [19:0] imm, input int rd, input logic [6:0] opc);
    return {imm, 5'(rd), opc};
  endfunction

  function automatic word_t enc_j(input logic [20:0] imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), OPC_JAL};
  endfunction

  function automatic word_t enc_csr(input logic [11:0] ca, input int rs1, input logic [2:0] f3,
                                    input int rd);
    return enc_i(ca, rs1, f3, rd, OPC_SYSTEM);
  endfunction

  function automatic int pick_reg();
    return 1 + (($random(seed) & 32'h7fff_ffff) % 15);  // x1 to x15
  endfunction

  task automatic put(input word_t w);
    imem[wp] = w;
    wp++;
  endtask

  task automatic begin_program();
    @(posedge clk);
    #1;
    arst_n = 1'b0;
    for (int i = 0; i < 1024; i++) imem[i] = '0;
    wp = 0;
  endtask

  // Close with a jump to itself, release reset and wait for it
  task automatic run_program(input string name);
    put(enc_j(21'd0, 0));
    end_pc = RESET_PC + 32'(4 * (wp - 1));
    repeat (5) @(posedge clk);
    #1;
    arst_n = 1'b1;
    while (retire.pc !== end_pc) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    chk.end_test(name);
  endtask

  task automatic test_reset();
    begin_program();
    put(enc_i(12'd5, 0, 3'd0, 0, OPC_OPIMM));  // Write to x0
    put(enc_i(12'd0, 0, 3'd0, 1, OPC_OPIMM));
    put(enc_r(7'h00, 0, 0, 3'd0, 2));
    put(enc_csr(CSR_MSTATUS, 0, 3'd2, 3));
    run_program("reset");
  endtask

  task automatic test_alu();
    int         kind;
    logic [2:0] f3;
    logic [11:0] imm;
    logic [6:0] f7;
    begin_program();
    for (int r = 1; r < 16; r++) put(enc_u(20'($random(seed)), r, OPC_LUI));
    for (int i = 0; i < 300; i++) begin
      kind = ($random(seed) & 32'h7fff_ffff) % 8;
      f3   = 3'($random(seed));
      imm  = 12'($random(seed));
      if (kind == 0) begin
        put(enc_u(20'($random(seed)), pick_reg(), OPC_LUI));
      end else if (kind == 1) begin
        put(enc_u(20'($random(seed)), pick_reg(), OPC_AUIPC));
      end else if (kind < 5) begin
        if (f3 == 3'd1) imm[11:5] = 7'h00;
        if (f3 == 3'd5) imm[11:5] = imm[11] ? 7'h20 : 7'h00;
        put(enc_i(imm, pick_reg(), f3, pick_reg(), OPC_OPIMM));
      end else begin
        f7 = ((f3 == 3'd0 || f3 == 3'd5) && imm[0]) ? 7'h20 : 7'h00;
        put(enc_r(f7, pick_reg(), pick_reg(), f3, pick_reg()));
      end
    end
    run_program("alu");
  endtask

  task automatic test_branch();
    logic [2:0]  f3s [6];
    logic [11:0] va [3];
    logic [11:0] vb [3];
    f3s = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    va  = '{12'hffd, 12'd5, 12'd4};
    vb  = '{12'd5, 12'hffd, 12'd4};
    begin_program();
    foreach (f3s[t]) begin
      for (int p = 0; p < 3; p++) begin
        put(enc_i(va[p], 0, 3'd0, 1, OPC_OPIMM));
        put(enc_i(vb[p], 0, 3'd0, 2, OPC_OPIMM));
        put(enc_b(13'd8, 2, 1, f3s[t]));
        put(enc_i(12'd1, 3, 3'd0, 3, OPC_OPIMM));  // Skipped when taken
      end
    end
    put(enc_j(21'd8, 5));
    put(enc_i(12'd1, 3, 3'd0, 3, OPC_OPIMM));
    put(enc_u(20'd0, 6, OPC_AUIPC));
    put(enc_i(12'd13, 6, 3'd0, 7, OPC_JALR));  // Bit 0 of target cleared
    put(enc_i(12'd1, 3, 3'd0, 3, OPC_OPIMM));
    put(enc_i(12'd0, 7, 3'd0, 8, OPC_OPIMM));
    run_program("branch");
  endtask

  task automatic test_memory();
    begin_program();
    put(enc_u(20'h80010, 10, OPC_LUI));
    for (int k = 0; k < 4; k++) begin
      put(enc_u(20'($random(seed)), 11, OPC_LUI));
      put(enc_i(12'($random(seed)), 11, 3'd0, 11, OPC_OPIMM));
      put(enc_s(12'(k), 11, 10, 3'd0));
      put(enc_i(12'(k), 10, 3'd0, 12, OPC_LOAD));
      put(enc_i(12'(k), 10, 3'd4, 13, OPC_LOAD));
      if (k < 3) begin
        put(enc_s(12'(16 + k), 11, 10, 3'd1));
        put(enc_i(12'(16 + k), 10, 3'd1, 12, OPC_LOAD));
        put(enc_i(12'(16 + k), 10, 3'd5, 13, OPC_LOAD));
      end
      put(enc_s(12'(32 + 4 * k), 11, 10, 3'd2));
      put(enc_i(12'(32 + 4 * k), 10, 3'd2, 14, OPC_LOAD));
      put(enc_i(12'(64 + k), 10, 3'd0, 15, OPC_LOAD));  // Untouched fill
    end
    run_program("memory");
  endtask

  task automatic test_csr();
    logic [11:0] cas [4];
    cas = '{CSR_MSTATUS, CSR_MTVEC, CSR_MEPC, CSR_MCAUSE};
    begin_program();
    foreach (cas[c]) begin
      put(enc_u(20'($random(seed)), 1, OPC_LUI));
      put(enc_csr(cas[c], 1, 3'd1, 2));
      put(enc_i(12'($random(seed)), 0, 3'd0, 1, OPC_OPIMM));
      put(enc_csr(cas[c], 1, 3'd2, 3));
      put(enc_csr(cas[c], 0, 3'd2, 4));
    end
    put(enc_csr(12'h7c0, 1, 3'd1, 5));  // Unknown CSR reads zero
    put(enc_i(12'd8, 0, 3'd0, 1, OPC_OPIMM));
    put(enc_csr(CSR_MSTATUS, 1, 3'd1, 0));
    put(enc_u(20'h80000, 4, OPC_LUI));
    put(enc_i(12'(4 * (wp + 5)), 4, 3'd0, 4, OPC_OPIMM));  // Handler after the end loop
    put(enc_csr(CSR_MTVEC, 4, 3'd1, 5));
    put(32'h0000_0073);
    put(enc_csr(CSR_MSTATUS, 0, 3'd2, 9));
    put(enc_j(21'd0, 0));
    put(enc_csr(CSR_MEPC, 0, 3'd2, 6));
    put(enc_csr(CSR_MCAUSE, 0, 3'd2, 7));
    put(enc_csr(CSR_MSTATUS, 0, 3'd2, 8));
    put(enc_i(12'd4, 6, 3'd0, 6, OPC_OPIMM));
    put(enc_csr(CSR_MEPC, 6, 3'd1, 0));
    put(32'h3020_0073);
    wp = wp - 7;  // End loop is the jump placed above
    end_pc = RESET_PC + 32'(4 * wp);
    repeat (5) @(posedge clk);
    #1;
    arst_n = 1'b1;
    while (retire.pc !== end_pc) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    chk.end_test("csr");
  endtask

  initial begin
    arst_n = 1'b0;
    seed   = 32'h91a0;
    cycles = 0;
    for (int i = 0; i < 1024; i++) imem[i] = '0;
    test_reset();
    test_alu();
    test_branch();
    test_memory();
    test_csr();
    $display("tests %0d, checks %0d, errors %0d", chk.tests_run, chk.checks_all, chk.err_total);
    if (chk.err_total == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* rv_core.f */
rv_isa_pkg.sv
rv_csr_pkg.sv
rv_decoder.sv
rv_regfile.sv
rv_int_exec.sv
rv_csr_unit.sv
rv_commit.sv
rv_core.sv
tb_rv_checker.sv
tb_rv_core.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f rv_core.f --top-module tb_rv_core -o sim_rv_core

out=$(./obj_dir/sim_rv_core)
echo "$out"

if echo "$out" | grep -qF "=== PASS ==="; then
  exit 0
else
  exit 1
fi
